/* src/clksync_pkg.sv */
// --------------------
// clksync shared definitions
// config word layout, register address, opcode and decoder state types
// --------------------
`default_nettype none

package clksync_pkg;

  // width of both configuration words
  localparam int CFG_W = 20;

  // --------------------
  // downstream word fields
  localparam int CFG_DN_DATA_LO = 0;
  localparam int CFG_DN_DATA_HI = 15;
  localparam int CFG_DN_ADDR_LO = 16;
  localparam int CFG_DN_ADDR_HI = 17;
  localparam int CFG_DN_EN      = 18;
  localparam int CFG_DN_WE      = 19;

  // --------------------
  // upstream word fields
  localparam int CFG_UP_DATA_LO = 0;
  localparam int CFG_UP_DATA_HI = 15;
  localparam int CFG_UP_ACCEPT  = 16;
  localparam int CFG_UP_RVALID  = 17;
  localparam int CFG_UP_IS_ACM  = 18;
  localparam int CFG_UP_PRESENT = 19;

  // sync delay register lives at this address
  localparam int CFG_ADDR_SYNC_DELAY = 3;

  // delay value width, the line is 2**width deep
  localparam int DELAY_W_DEFAULT = 6;

  // frame payload: 2 opcode bits then the event id, msb first
  localparam int EVENT_ID_W = 8;
  localparam int FRAME_BITS = 10;

  // frame opcodes as sent on the sync line
  typedef enum logic [1:0] {
    OP_RESET   = 2'd0,
    OP_STROBE1 = 2'd1,
    OP_STROBE2 = 2'd2,
    OP_EVENT   = 2'd3
  } sync_op_e;

  // decoder states
  typedef enum logic [1:0] {
    RX_IDLE,
    RX_OPCODE,
    RX_DATA
  } rx_state_e;

endpackage

`default_nettype wire

/* src/clksync_cfg_port.sv */
// --------------------
// clksync config port
// holds the sync delay register and sends new values to the core domain
// --------------------
`timescale 1ns/1ps
`default_nettype none

module clksync_cfg_port import clksync_pkg::*; #(
  parameter int DELAY_W = DELAY_W_DEFAULT
) (
  input  wire logic               cfg_clk_i,
  input  wire logic               cfg_rst_i,
  input  wire logic [CFG_W-1:0]   cfg_dn_i,
  output logic      [CFG_W-1:0]   cfg_up_o,
  // handshake towards the core domain
  output logic                    delay_req_o,
  input  wire logic               delay_ack_i,
  output logic      [DELAY_W-1:0] delay_o
);

  localparam int ADDR_W    = CFG_DN_ADDR_HI - CFG_DN_ADDR_LO + 1;
  localparam int UP_DATA_W = CFG_UP_DATA_HI - CFG_UP_DATA_LO + 1;

  logic              wr_hit;
  logic              wr_take;
  logic              accept;
  logic              req_q;
  logic              ack_meta_q;
  logic              ack_sync_q;
  logic [DELAY_W-1:0] delay_q;

  // --------------------
  // write decode
  // enabled write aimed at the delay register
  assign wr_hit = cfg_dn_i[CFG_DN_EN] & cfg_dn_i[CFG_DN_WE] &
                  (cfg_dn_i[CFG_DN_ADDR_HI:CFG_DN_ADDR_LO] ==
                   ADDR_W'(CFG_ADDR_SYNC_DELAY));

  // busy until the ack has come back and dropped again
  assign accept  = ~(req_q | ack_sync_q);
  // writes seen while busy are simply lost
  assign wr_take = wr_hit & accept;

  // --------------------
  // request side of the handshake
  always_ff @(posedge cfg_clk_i or posedge cfg_rst_i) begin
    if (cfg_rst_i) begin
      ack_meta_q <= 1'b0;
      ack_sync_q <= 1'b0;
      req_q      <= 1'b0;
    end else begin
      // two flop sync of the core side ack
      ack_meta_q <= delay_ack_i;
      ack_sync_q <= ack_meta_q;
      if (wr_take) begin
        req_q <= 1'b1;
      end else if (ack_sync_q) begin
        // core has loaded the value, release the level
        req_q <= 1'b0;
      end
    end
  end

  // config side copy of the delay, also what reads return
  always_ff @(posedge cfg_clk_i or posedge cfg_rst_i) begin
    if (cfg_rst_i) begin
      delay_q <= '0;
    end else if (wr_take) begin
      delay_q <= cfg_dn_i[CFG_DN_DATA_LO +: DELAY_W];
    end
  end

  assign delay_req_o = req_q;
  assign delay_o     = delay_q;

  // --------------------
  // upstream word
  assign cfg_up_o[CFG_UP_DATA_HI:CFG_UP_DATA_LO] = {{(UP_DATA_W-DELAY_W){1'b0}}, delay_q};
  assign cfg_up_o[CFG_UP_ACCEPT]  = accept;
  // read data is always valid, so rvalid just mirrors a read access
  assign cfg_up_o[CFG_UP_RVALID]  = cfg_dn_i[CFG_DN_EN] & ~cfg_dn_i[CFG_DN_WE];
  // identify as a clock sync port, not an acm
  assign cfg_up_o[CFG_UP_IS_ACM]  = 1'b0;
  assign cfg_up_o[CFG_UP_PRESENT] = 1'b1;

  // core side samples delay_o any time the request is up
  a_delay_stable_during_req: assert property (
    @(posedge cfg_clk_i) disable iff (cfg_rst_i)
    delay_req_o |=> $stable(delay_o)
  ) else $error("delay_o changed while delay_req_o was high");

endmodule

`default_nettype wire

/* src/clksync_delay_cdc.sv */
// --------------------
// clksync delay crossing
// brings a new delay value into clk_i and returns the ack
// --------------------
`timescale 1ns/1ps
`default_nettype none

module clksync_delay_cdc import clksync_pkg::*; #(
  parameter int DELAY_W = DELAY_W_DEFAULT
) (
  input  wire logic               clk_i,
  input  wire logic               rst_i,
  input  wire logic               core_rst_i,
  input  wire logic               delay_req_i,
  input  wire logic [DELAY_W-1:0] delay_i,
  output logic                    delay_ack_o,
  output logic      [DELAY_W-1:0] core_delay_o
);

  logic               req_meta_q;
  logic               req_sync_q;
  logic               ack_q;
  logic               load;
  logic [DELAY_W-1:0] core_delay_q;

  // --------------------
  // request sync and ack stage
  always_ff @(posedge clk_i or posedge core_rst_i) begin
    if (core_rst_i) begin
      req_meta_q <= 1'b0;
      req_sync_q <= 1'b0;
      ack_q      <= 1'b0;
    end else begin
      req_meta_q <= delay_req_i;
      req_sync_q <= req_meta_q;
      // third stage doubles as the ack and the edge detector
      ack_q      <= req_sync_q;
    end
  end

  // first cycle the synchronized request is seen
  assign load = req_sync_q & ~ack_q;

  // --------------------
  // core delay register
  // survives config resets and lock loss, only rst_i clears it
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      core_delay_q <= '0;
    end else if (load) begin
      // delay_i is held by the config side while the request is up
      core_delay_q <= delay_i;
    end
  end

  assign delay_ack_o  = ack_q;
  assign core_delay_o = core_delay_q;

endmodule

`default_nettype wire

/* src/clksync_reset_gen.sv */
// --------------------
// clksync core reset
// merges reset, config reset and lock loss, stretches the release
// --------------------
`timescale 1ns/1ps
`default_nettype none

module clksync_reset_gen (
  input  wire logic clk_i,
  input  wire logic rst_i,
  input  wire logic cfg_rst_i,
  input  wire logic clk_locked_i,
  output logic      core_rst_o
);

  logic [1:0] cfg_rst_sync_q;
  logic       rst_any;
  logic [2:0] stretch_q;

  // cfg_rst_i comes from the slow domain, two flops into clk_i
  // held asserted while rst_i is up
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      cfg_rst_sync_q <= 2'b11;
    end else begin
      cfg_rst_sync_q <= {cfg_rst_sync_q[0], cfg_rst_i};
    end
  end

  // rst_i and lock loss go straight in, no sync needed to assert
  assign rst_any = rst_i | cfg_rst_sync_q[1] | ~clk_locked_i;

  // shifter keeps the core in reset 3 cycles past release
  always_ff @(posedge clk_i or posedge rst_any) begin
    if (rst_any) begin
      stretch_q <= 3'b111;
    end else begin
      stretch_q <= {1'b0, stretch_q[2:1]};
    end
  end

  assign core_rst_o = stretch_q[0];

endmodule

`default_nettype wire

/* src/sync_delay_line.sv */
// --------------------
// sync delay line
// programmable delay of the sampled sync bit, tap picked by delay_i
// --------------------
`timescale 1ns/1ps
`default_nettype none

module sync_delay_line import clksync_pkg::*; #(
  parameter int DELAY_W = DELAY_W_DEFAULT
) (
  input  wire logic               clk_i,
  input  wire logic               core_rst_i,
  input  wire logic               sync_i,
  input  wire logic [DELAY_W-1:0] delay_i,
  output logic                    sync_o
);

  localparam int DEPTH = 2**DELAY_W;

  // line_q[0] is the input register
  // line_q[n] holds the sample n cycles older
  logic [DEPTH-1:0] line_q;
  logic             tap_q;

  // --------------------
  // shift and tap
  // cleared in reset so no stale frame bits leak out afterwards
  always_ff @(posedge clk_i or posedge core_rst_i) begin
    if (core_rst_i) begin
      line_q <= '0;
      tap_q  <= 1'b0;
    end else begin
      line_q <= {line_q[DEPTH-2:0], sync_i};
      // the registered tap makes delay 0 cost two cycles
      tap_q  <= line_q[delay_i];
    end
  end

  assign sync_o = tap_q;

endmodule

`default_nettype wire

/* src/sync_frame_decoder.sv */
// --------------------
// sync frame decoder
// start bit, 2 opcode bits and 8 id bits in, one event pulse out
// --------------------
`timescale 1ns/1ps
`default_nettype none

module sync_frame_decoder import clksync_pkg::*; (
  input  wire logic                  clk_i,
  input  wire logic                  core_rst_i,
  input  wire logic                  sync_i,
  output logic                       user_reset_o,
  output logic                       user_strobe1_o,
  output logic                       user_strobe2_o,
  output logic      [EVENT_ID_W-1:0] user_event_id_o,
  output logic                       user_event_en_o
);

  localparam int OP_BITS = FRAME_BITS - EVENT_ID_W;
  localparam int CNT_W   = $clog2(FRAME_BITS);

  rx_state_e            state_q;
  logic [CNT_W-1:0]     bit_cnt_q;
  logic [OP_BITS-1:0]   op_sh_q;
  logic [EVENT_ID_W-2:0] id_sh_q;
  sync_op_e             rx_op;
  logic                 last_bit;
  logic                 reset_q;
  logic                 strobe1_q;
  logic                 strobe2_q;
  logic                 event_en_q;
  logic [EVENT_ID_W-1:0] event_id_q;

  assign rx_op    = sync_op_e'(op_sh_q);
  // final id bit is on sync_i right now
  assign last_bit = (state_q == RX_DATA) && (bit_cnt_q == CNT_W'(FRAME_BITS-1));

  // --------------------
  // frame state machine
  always_ff @(posedge clk_i or posedge core_rst_i) begin
    if (core_rst_i) begin
      state_q   <= RX_IDLE;
      bit_cnt_q <= '0;
    end else begin
      case (state_q)
        RX_IDLE: begin
          // line idles low, first 1 is the start bit
          if (sync_i) begin
            state_q   <= RX_OPCODE;
            bit_cnt_q <= '0;
          end
        end
        RX_OPCODE: begin
          bit_cnt_q <= bit_cnt_q + 1'b1;
          if (bit_cnt_q == CNT_W'(OP_BITS-1)) begin
            state_q <= RX_DATA;
          end
        end
        RX_DATA: begin
          bit_cnt_q <= bit_cnt_q + 1'b1;
          if (last_bit) begin
            // back to back frames are fine, next edge can be a start bit
            state_q   <= RX_IDLE;
            bit_cnt_q <= '0;
          end
        end
        default: begin
          state_q <= RX_IDLE;
        end
      endcase
    end
  end

  // payload shifters, msb first
  always_ff @(posedge clk_i) begin
    if (state_q == RX_OPCODE) begin
      op_sh_q <= {op_sh_q[OP_BITS-2:0], sync_i};
    end
    if (state_q == RX_DATA) begin
      id_sh_q <= {id_sh_q[EVENT_ID_W-3:0], sync_i};
    end
  end

  // --------------------
  // output pulses
  always_ff @(posedge clk_i or posedge core_rst_i) begin
    if (core_rst_i) begin
      reset_q    <= 1'b0;
      strobe1_q  <= 1'b0;
      strobe2_q  <= 1'b0;
      event_en_q <= 1'b0;
    end else begin
      reset_q    <= last_bit && (rx_op == OP_RESET);
      strobe1_q  <= last_bit && (rx_op == OP_STROBE1);
      strobe2_q  <= last_bit && (rx_op == OP_STROBE2);
      event_en_q <= last_bit && (rx_op == OP_EVENT);
    end
  end

  // id only moves with an event pulse, ignored for other opcodes
  always_ff @(posedge clk_i) begin
    if (last_bit && (rx_op == OP_EVENT)) begin
      event_id_q <= {id_sh_q, sync_i};
    end
  end

  assign user_reset_o    = reset_q;
  assign user_strobe1_o  = strobe1_q;
  assign user_strobe2_o  = strobe2_q;
  assign user_event_en_o = event_en_q;
  assign user_event_id_o = event_id_q;

  // one frame gives one event kind
  a_one_pulse: assert property (
    @(posedge clk_i) disable iff (core_rst_i)
    $onehot0({user_reset_o, user_strobe1_o, user_strobe2_o, user_event_en_o})
  ) else $error("more than one user pulse in a cycle");

endmodule

`default_nettype wire

/* src/clksync_top.sv */
// --------------------
// clksync top
// config port, delay crossing, reset, delay line and frame decoder
// --------------------
`timescale 1ns/1ps
`default_nettype none

module clksync_top import clksync_pkg::*; #(
  parameter int DELAY_W = DELAY_W_DEFAULT
) (
  // core clock domain
  input  wire logic                  clk_i,
  input  wire logic                  rst_i,
  input  wire logic                  clk_locked_i,
  input  wire logic                  sync_i,
  // config clock domain
  input  wire logic                  cfg_clk_i,
  input  wire logic                  cfg_rst_i,
  input  wire logic [CFG_W-1:0]      cfg_dn_i,
  output logic      [CFG_W-1:0]      cfg_up_o,
  // user events
  output logic                       user_reset_o,
  output logic                       user_strobe1_o,
  output logic                       user_strobe2_o,
  output logic      [EVENT_ID_W-1:0] user_event_id_o,
  output logic                       user_event_en_o
);

  logic               delay_req;
  logic               delay_ack;
  logic [DELAY_W-1:0] cfg_delay;
  logic [DELAY_W-1:0] core_delay;
  logic               core_rst;
  logic               sync_dly;

  // --------------------
  // config domain
  clksync_cfg_port #(.DELAY_W(DELAY_W)) u_cfg_port (
    .cfg_clk_i   (cfg_clk_i),
    .cfg_rst_i   (cfg_rst_i),
    .cfg_dn_i    (cfg_dn_i),
    .cfg_up_o    (cfg_up_o),
    .delay_req_o (delay_req),
    .delay_ack_i (delay_ack),
    .delay_o     (cfg_delay)
  );

  // --------------------
  // core domain
  clksync_delay_cdc #(.DELAY_W(DELAY_W)) u_delay_cdc (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .core_rst_i   (core_rst),
    .delay_req_i  (delay_req),
    .delay_i      (cfg_delay),
    .delay_ack_o  (delay_ack),
    .core_delay_o (core_delay)
  );

  clksync_reset_gen u_reset_gen (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .cfg_rst_i    (cfg_rst_i),
    .clk_locked_i (clk_locked_i),
    .core_rst_o   (core_rst)
  );

  sync_delay_line #(.DELAY_W(DELAY_W)) u_delay_line (
    .clk_i      (clk_i),
    .core_rst_i (core_rst),
    .sync_i     (sync_i),
    .delay_i    (core_delay),
    .sync_o     (sync_dly)
  );

  sync_frame_decoder u_frame_decoder (
    .clk_i           (clk_i),
    .core_rst_i      (core_rst),
    .sync_i          (sync_dly),
    .user_reset_o    (user_reset_o),
    .user_strobe1_o  (user_strobe1_o),
    .user_strobe2_o  (user_strobe2_o),
    .user_event_id_o (user_event_id_o),
    .user_event_en_o (user_event_en_o)
  );

endmodule

`default_nettype wire

/* tb/tb_clksync.sv */
// --------------------
// clksync testbench
// config handshake, random frames against a timing model, reset and lock loss
// --------------------
`timescale 1ns/1ps
`default_nettype none

module tb_clksync import clksync_pkg::*; ();

  localparam int DELAY_W     = DELAY_W_DEFAULT;
  localparam int LINE_DEPTH  = 2**DELAY_W;
  localparam int RAND_FRAMES = 32;
  localparam int DLY_FRAMES  = 8;
  localparam int RST_FRAMES  = 6;
  localparam int N_FRAMES    = RAND_FRAMES + 4*DLY_FRAMES + 2*(RST_FRAMES + 2);
  // start bit edge to pulse window without the programmed delay
  localparam int PIPE_LAT    = 12;
  localparam int ACCEPT_MAX  = 20;
  localparam logic [1:0] DLY_ADDR = 2'(CFG_ADDR_SYNC_DELAY);

  logic                  clk_i;
  logic                  rst_i;
  logic                  cfg_clk_i;
  logic                  cfg_rst_i;
  logic                  clk_locked_i;
  logic                  sync_i;
  logic [CFG_W-1:0]      cfg_dn_i;
  logic [CFG_W-1:0]      cfg_up_o;
  logic                  user_reset_o;
  logic                  user_strobe1_o;
  logic                  user_strobe2_o;
  logic [EVENT_ID_W-1:0] user_event_id_o;
  logic                  user_event_en_o;

  int          cyc = 0;
  int          err_cnt = 0;
  int          sent_cnt = 0;
  int          pulse_cnt = 0;
  int          cur_delay = 0;
  logic [31:0] rnd_state = 32'hb7955b8d;
  logic        chk_en = 1'b0;

  // one queue entry per checked frame
  int                    due_q[$];
  sync_op_e              op_q[$];
  logic [EVENT_ID_W-1:0] id_q[$];

  // outputs and expectations as taken at the falling edge
  logic                  got_reset;
  logic                  got_s1;
  logic                  got_s2;
  logic                  got_ev;
  logic                  exp_reset;
  logic                  exp_s1;
  logic                  exp_s2;
  logic                  exp_ev;
  logic [EVENT_ID_W-1:0] got_id;
  logic [EVENT_ID_W-1:0] exp_id;
  logic [EVENT_ID_W-1:0] id_prev;
  logic id_seen = 1'b0;
  logic id_hold_chk = 1'b0;

  clksync_top #(.DELAY_W(DELAY_W)) u_dut (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .clk_locked_i    (clk_locked_i),
    .sync_i          (sync_i),
    .cfg_clk_i       (cfg_clk_i),
    .cfg_rst_i       (cfg_rst_i),
    .cfg_dn_i        (cfg_dn_i),
    .cfg_up_o        (cfg_up_o),
    .user_reset_o    (user_reset_o),
    .user_strobe1_o  (user_strobe1_o),
    .user_strobe2_o  (user_strobe2_o),
    .user_event_id_o (user_event_id_o),
    .user_event_en_o (user_event_en_o)
  );

  // --------------------
  // clocks and cycle count
  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  initial begin
    cfg_clk_i = 1'b0;
    forever #13 cfg_clk_i = ~cfg_clk_i;
  end

  always @(posedge clk_i) cyc <= cyc + 1;

  function automatic logic [31:0] next_rand(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    err_cnt++;
    $display("ERR %s got %0h exp %0h at %0t", name, got, exp, $time);
  endtask

  task automatic check_field(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else report_mismatch(name, got, exp);
  endtask

  // --------------------
  // reference model
  // window after edge n is seen at the falling edge with cyc == n
  always @(negedge clk_i) begin
    id_prev   = got_id;
    got_reset = user_reset_o;
    got_s1    = user_strobe1_o;
    got_s2    = user_strobe2_o;
    got_ev    = user_event_en_o;
    got_id    = user_event_id_o;
    // id must hold unless a new event comes with it
    id_hold_chk = id_seen && !got_ev;
    if (got_ev) id_seen = 1'b1;
    if (got_reset || got_s1 || got_s2 || got_ev) pulse_cnt++;
    exp_reset = 1'b0;
    exp_s1    = 1'b0;
    exp_s2    = 1'b0;
    exp_ev    = 1'b0;
    if (due_q.size() > 0 && due_q[0] == cyc) begin
      case (op_q[0])
        OP_RESET:   exp_reset = 1'b1;
        OP_STROBE1: exp_s1    = 1'b1;
        OP_STROBE2: exp_s2    = 1'b1;
        default:    exp_ev    = 1'b1;
      endcase
      exp_id = id_q[0];
      void'(due_q.pop_front());
      void'(op_q.pop_front());
      void'(id_q.pop_front());
    end
  end

  // --------------------
  // output checks
  a_reset: assert property (@(posedge clk_i) disable iff (!chk_en) got_reset == exp_reset)
    else report_mismatch("user_reset_o", 32'(got_reset), 32'(exp_reset));
  a_strobe1: assert property (@(posedge clk_i) disable iff (!chk_en) got_s1 == exp_s1)
    else report_mismatch("user_strobe1_o", 32'(got_s1), 32'(exp_s1));
  a_strobe2: assert property (@(posedge clk_i) disable iff (!chk_en) got_s2 == exp_s2)
    else report_mismatch("user_strobe2_o", 32'(got_s2), 32'(exp_s2));
  a_event_en: assert property (@(posedge clk_i) disable iff (!chk_en) got_ev == exp_ev)
    else report_mismatch("user_event_en_o", 32'(got_ev), 32'(exp_ev));
  a_event_id: assert property (@(posedge clk_i) disable iff (!chk_en)
    (exp_ev && got_ev) |-> (got_id == exp_id))
    else report_mismatch("user_event_id_o", 32'(got_id), 32'(exp_id));
  a_id_hold: assert property (@(posedge clk_i) disable iff (!chk_en)
    id_hold_chk |-> (got_id == id_prev))
    else report_mismatch("user_event_id_o", 32'(got_id), 32'(id_prev));

  // --------------------
  // config side
  task automatic cfg_drive(input logic en, input logic we, input logic [1:0] addr,
                           input logic [15:0] data);
    @(posedge cfg_clk_i);
    #1;
    cfg_dn_i = '0;
    cfg_dn_i[CFG_DN_EN] = en;
    cfg_dn_i[CFG_DN_WE] = we;
    cfg_dn_i[CFG_DN_ADDR_HI:CFG_DN_ADDR_LO] = addr;
    cfg_dn_i[CFG_DN_DATA_HI:CFG_DN_DATA_LO] = data;
  endtask

  // sampled mid cycle so rvalid follows the word driven in this cycle
  task automatic check_up(input logic [15:0] exp_data, input logic exp_accept,
                          input logic exp_rvalid);
    @(negedge cfg_clk_i);
    check_field("cfg_up_o.data", 32'(cfg_up_o[CFG_UP_DATA_HI:CFG_UP_DATA_LO]), 32'(exp_data));
    check_field("cfg_up_o.accept", 32'(cfg_up_o[CFG_UP_ACCEPT]), 32'(exp_accept));
    check_field("cfg_up_o.rvalid", 32'(cfg_up_o[CFG_UP_RVALID]), 32'(exp_rvalid));
    check_field("cfg_up_o.is_acm", 32'(cfg_up_o[CFG_UP_IS_ACM]), 32'd0);
    check_field("cfg_up_o.present", 32'(cfg_up_o[CFG_UP_PRESENT]), 32'd1);
  endtask

  task automatic wait_accept();
    int n;
    n = 0;
    @(negedge cfg_clk_i);
    while (cfg_up_o[CFG_UP_ACCEPT] !== 1'b1 && n < ACCEPT_MAX) begin
      @(negedge cfg_clk_i);
      n++;
    end
    assert (cfg_up_o[CFG_UP_ACCEPT] === 1'b1) else begin
      err_cnt++;
      $display("accept did not come back within %0d cfg_clk_i cycles", ACCEPT_MAX);
    end
  endtask

  task automatic write_delay(input logic [15:0] value);
    cfg_drive(1'b1, 1'b1, DLY_ADDR, value);
    cfg_drive(1'b0, 1'b0, 2'd0, 16'h0);
    // handshake is busy once the write edge has passed
    @(negedge cfg_clk_i);
    check_field("cfg_up_o.accept", 32'(cfg_up_o[CFG_UP_ACCEPT]), 32'd0);
    wait_accept();
    cur_delay = int'(value[DELAY_W-1:0]);
    cfg_drive(1'b1, 1'b0, DLY_ADDR, 16'h0);
    check_up(value, 1'b1, 1'b1);
    cfg_drive(1'b0, 1'b0, 2'd0, 16'h0);
  endtask

  // --------------------
  // sync line
  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk_i);
      #1;
      sync_i = 1'b0;
    end
  endtask

  // raw bits msb first with no expected pulse
  task automatic send_bits(input logic [FRAME_BITS:0] word, input int n);
    int i;
    for (i = 0; i < n; i++) begin
      @(posedge clk_i);
      #1;
      sync_i = word[FRAME_BITS - i];
    end
  endtask

  task automatic send_frame(input sync_op_e op, input logic [EVENT_ID_W-1:0] id);
    logic [FRAME_BITS:0] word;
    int i;
    word = {1'b1, op, id};
    @(posedge clk_i);
    #1;
    // start bit is taken on the next edge
    due_q.push_back(cyc + 1 + PIPE_LAT + cur_delay);
    op_q.push_back(op);
    id_q.push_back(id);
    sent_cnt++;
    sync_i = word[FRAME_BITS];
    for (i = FRAME_BITS - 1; i >= 0; i--) begin
      @(posedge clk_i);
      #1;
      sync_i = word[i];
    end
  endtask

  task automatic drain();
    int n;
    n = 0;
    idle(1);
    while (due_q.size() > 0 && n < 200) begin
      @(posedge clk_i);
      n++;
    end
    assert (due_q.size() == 0) else begin
      err_cnt++;
      $display("%0d expected pulses never came due", due_q.size());
      due_q.delete();
      op_q.delete();
      id_q.delete();
    end
    // a longer tap would replay old frame bits still in the line
    idle(LINE_DEPTH);
  endtask

  // first four frames walk all opcodes
  // random gaps of 0 to 3 idle bits between frames
  task automatic run_random_frames(input int n);
    int k;
    sync_op_e op;
    for (k = 0; k < n; k++) begin
      rnd_state = next_rand(rnd_state);
      op = (k < 4) ? sync_op_e'(k[1:0]) : sync_op_e'(rnd_state[31:30]);
      send_frame(op, rnd_state[23:16]);
      idle(int'(rnd_state[9:8]));
    end
    drain();
  endtask

  task automatic lock_loss_test();
    logic [FRAME_BITS:0] word;
    rnd_state = next_rand(rnd_state);
    word = {1'b1, OP_EVENT, rnd_state[15:8]};
    // lock drops in the middle of a frame
    send_bits(word, 6);
    clk_locked_i = 1'b0;
    send_bits(word, FRAME_BITS + 1);
    idle(8);
    clk_locked_i = 1'b1;
    // lone start bit lands inside the 3 cycle stretch
    send_bits({1'b1, {FRAME_BITS{1'b0}}}, 1);
    idle(20);
    run_random_frames(RST_FRAMES);
  endtask

  task automatic cfg_reset_test();
    logic [FRAME_BITS:0] word;
    rnd_state = next_rand(rnd_state);
    word = {1'b1, OP_STROBE1, rnd_state[15:8]};
    @(posedge cfg_clk_i);
    #1;
    cfg_rst_i = 1'b1;
    // frame is cut once the reset has crossed into clk_i
    send_bits(word, FRAME_BITS + 1);
    idle(1);
    @(posedge cfg_clk_i);
    #1;
    cfg_rst_i = 1'b0;
    idle(20);
    run_random_frames(RST_FRAMES);
  endtask

  // --------------------
  // watchdog
  initial begin
    repeat (N_FRAMES * 100 + 5000) @(posedge clk_i);
    $display("timeout, test sequence did not finish in %0d cycles", N_FRAMES * 100 + 5000);
    $display("ERRORS FOUND");
    $finish;
  end

  // --------------------
  // main sequence
  initial begin
    rst_i        = 1'b1;
    cfg_rst_i    = 1'b1;
    clk_locked_i = 1'b1;
    sync_i       = 1'b0;
    cfg_dn_i     = '0;
    repeat (16) @(posedge clk_i);
    #1;
    rst_i = 1'b0;
    @(posedge cfg_clk_i);
    #1;
    cfg_rst_i = 1'b0;
    chk_en = 1'b1;
    idle(10);

    // power-on upstream word with rvalid on a read only
    check_up(16'h0, 1'b1, 1'b0);
    cfg_drive(1'b1, 1'b0, DLY_ADDR, 16'h0);
    check_up(16'h0, 1'b1, 1'b1);
    cfg_drive(1'b0, 1'b0, 2'd0, 16'h0);

    run_random_frames(RAND_FRAMES);
    write_delay(16'd1);
    run_random_frames(DLY_FRAMES);

    // second write lands while busy and is lost
    cfg_drive(1'b1, 1'b1, DLY_ADDR, 16'd17);
    cfg_drive(1'b1, 1'b1, DLY_ADDR, 16'd37);
    cfg_drive(1'b0, 1'b0, 2'd0, 16'h0);
    wait_accept();
    cur_delay = 17;
    check_up(16'd17, 1'b1, 1'b0);
    // other address leaves the register alone
    cfg_drive(1'b1, 1'b1, 2'd1, 16'd63);
    cfg_drive(1'b0, 1'b0, 2'd0, 16'h0);
    check_up(16'd17, 1'b1, 1'b0);
    run_random_frames(DLY_FRAMES);

    write_delay(16'd63);
    run_random_frames(DLY_FRAMES);
    lock_loss_test();
    cfg_reset_test();
    write_delay(16'd0);
    run_random_frames(DLY_FRAMES);

    check_field("pulse_cnt", 32'(pulse_cnt), 32'(sent_cnt));
    $display("frames %0d, pulses %0d, errors %0d", sent_cnt, pulse_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
src/clksync_pkg.sv
src/clksync_cfg_port.sv
src/clksync_delay_cdc.sv
src/clksync_reset_gen.sv
src/sync_delay_line.sv
src/sync_frame_decoder.sv
src/clksync_top.sv
tb/tb_clksync.sv

/* run.sh */
#!/bin/sh
# build and run the clksync testbench with verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
  -f vlog.f --top-module tb_clksync -Mdir obj_dir -o sim_clksync

# keep the log even if the simulator exits with an error
./obj_dir/sim_clksync > sim.log 2>&1 || true
cat sim.log

# the pass line must be present on its own
if grep -qx "NO ERRORS" sim.log; then
  echo "clksync simulation passed"
else
  echo "clksync simulation failed"
  exit 1
fi
